// ==== rtl/clock_pkg.sv ====
// Shared types and constants for the six-digit clock
// Divider defaults assume a 50 MHz board clock
// Segment bus is ordered a down to g, active high
package clock_pkg;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	// Encoding matches digit index divided by two on the display
	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_e;

	localparam int FIELD_W = 6;
	localparam logic [FIELD_W-1:0] SEC_MAX  = 6'd59;
	localparam logic [FIELD_W-1:0] MIN_MAX  = 6'd59;
	localparam logic [FIELD_W-1:0] HOUR_MAX = 6'd23;

	localparam int DIGIT_W    = 4;
	localparam int SEG_W      = 7;
	localparam int NUM_DIGITS = 6;

	localparam logic [SEG_W-1:0] SEG_BLANK = 7'b000_0000;
	localparam logic [SEG_W-1:0] SEG_DIGIT_TABLE [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	// Cycles per pulse at 50 MHz
	localparam int DEF_SEC_DIV    = 50_000_000;
	localparam int DEF_SCAN_DIV   = 5_000;
	localparam int DEF_BLINK_DIV  = 2_500_000;
	localparam int DEF_SAMPLE_DIV = 500_000;

	// Field increment that wraps at its limit, no carry out
	function automatic logic [FIELD_W-1:0] inc_wrap(input logic [FIELD_W-1:0] value,
		input logic [FIELD_W-1:0] max_val);
		return (value >= max_val) ? '0 : value + 1'b1;
	endfunction

endpackage

// ==== rtl/tick_gen.sv ====
// Enable pulse generator, everything stays in the clk domain
// Each divider must be 2 or more
// First pulse arrives DIV cycles after reset release
module tick_gen import clock_pkg::*; #(
	parameter int SEC_DIV    = DEF_SEC_DIV,
	parameter int SCAN_DIV   = DEF_SCAN_DIV,
	parameter int BLINK_DIV  = DEF_BLINK_DIV,
	parameter int SAMPLE_DIV = DEF_SAMPLE_DIV
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_scan_tick,
	output logic o_blink,
	output logic o_sample_tick
);

	localparam int DIVS [4] = '{SEC_DIV, SCAN_DIV, BLINK_DIV, SAMPLE_DIV};

	// Terminal count of each counter: sec, scan, blink, sample
	logic [3:0] hit;
	logic [2:0] tick_q;
	logic       blink_q;

	for (genvar g = 0; g < 4; g++) begin : g_div
		localparam int CW = $clog2(DIVS[g]);
		logic [CW-1:0] cnt_q;

		assign hit[g] = (cnt_q == CW'(DIVS[g] - 1));

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				cnt_q <= '0;
			end else if (hit[g]) begin
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_q  <= '0;
			blink_q <= 1'b0;
		end else begin
			tick_q  <= {hit[3], hit[1], hit[0]};
			blink_q <= blink_q ^ hit[2];
		end
	end

	assign o_sec_tick    = tick_q[0];
	assign o_scan_tick   = tick_q[1];
	assign o_sample_tick = tick_q[2];
	assign o_blink       = blink_q;

endmodule

// ==== rtl/button_sync.sv ====
// Button synchronizer and debouncer for four active high buttons
// Bounce must settle within one sample period
// A press gives exactly one pulse, release gives none
module button_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sample_tick,
	input  logic [3:0] i_btn,
	output logic [3:0] o_press
);

	logic [3:0] sync_q1;
	logic [3:0] sync_q2;
	logic [3:0] samp_q;

	// ------------------------------------------------------------
	// Two-flop synchronizer
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= i_btn;
			sync_q2 <= sync_q1;
		end
	end

	// ------------------------------------------------------------
	// Slow sampling, previous level kept for edge detect
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_q <= '0;
		end else if (i_sample_tick) begin
			samp_q <= sync_q2;
		end
	end

	// Rising sampled level
	assign o_press = {4{i_sample_tick}} & sync_q2 & ~samp_q;

endmodule

// ==== rtl/mode_ctrl.sv ====
// Mode and field selection from debounced button presses
// Press bits: 0 mode, 1 position, 2 increment, 3 alarm enable
// Increment strobes are combinational from the press pulse
module mode_ctrl import clock_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] i_press,
	output mode_e      o_mode,
	output pos_e       o_pos,
	output logic       o_alarm_en,
	output logic       o_inc_time,
	output logic       o_inc_alarm
);

	mode_e mode_q;
	pos_e  pos_q;
	logic  alarm_en_q;

	// Mode FSM: clock -> setup -> alarm -> clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q <= MODE_CLOCK;
		end else if (i_press[0]) begin
			case (mode_q)
				MODE_CLOCK: mode_q <= MODE_SETUP;
				MODE_SETUP: mode_q <= MODE_ALARM;
				default:    mode_q <= MODE_CLOCK;
			endcase
		end
	end

	// Field select: sec -> min -> hour -> sec
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos_q <= POS_SEC;
		end else if (i_press[1]) begin
			case (pos_q)
				POS_SEC: pos_q <= POS_MIN;
				POS_MIN: pos_q <= POS_HOUR;
				default: pos_q <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_en_q <= 1'b0;
		end else if (i_press[3]) begin
			alarm_en_q <= ~alarm_en_q;
		end
	end

	assign o_mode     = mode_q;
	assign o_pos      = pos_q;
	assign o_alarm_en = alarm_en_q;

	// Increment is dropped in clock mode
	assign o_inc_time  = i_press[2] && (mode_q == MODE_SETUP);
	assign o_inc_alarm = i_press[2] && (mode_q == MODE_ALARM);

endmodule

// ==== rtl/hms_counter.sv ====
// Running time of day, 24 hour format
// Time is frozen in setup mode, only single field increments apply
// Setup increments wrap per field and never carry
module hms_counter import clock_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_sec_tick,
	input  mode_e              i_mode,
	input  pos_e               i_pos,
	input  logic               i_inc,
	output logic [FIELD_W-1:0] o_sec,
	output logic [FIELD_W-1:0] o_min,
	output logic [FIELD_W-1:0] o_hour
);

	logic [FIELD_W-1:0] sec_q;
	logic [FIELD_W-1:0] min_q;
	logic [FIELD_W-1:0] hour_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_q  <= '0;
			min_q  <= '0;
			hour_q <= '0;
		end else if (i_mode == MODE_SETUP) begin
			if (i_inc) begin
				case (i_pos)
					POS_SEC:  sec_q  <= inc_wrap(sec_q, SEC_MAX);
					POS_MIN:  min_q  <= inc_wrap(min_q, MIN_MAX);
					POS_HOUR: hour_q <= inc_wrap(hour_q, HOUR_MAX);
					default: begin
					end
				endcase
			end
		end else if (i_sec_tick) begin
			sec_q <= inc_wrap(sec_q, SEC_MAX);
			// Carry into minutes, then hours
			if (sec_q == SEC_MAX) begin
				min_q <= inc_wrap(min_q, MIN_MAX);
				if (min_q == MIN_MAX) begin
					hour_q <= inc_wrap(hour_q, HOUR_MAX);
				end
			end
		end
	end

	assign o_sec  = sec_q;
	assign o_min  = min_q;
	assign o_hour = hour_q;

endmodule

// ==== rtl/alarm_unit.sv ====
// Alarm time registers and alarm latch
// Alarm time is set field by field, no carry between fields
// Output latches on a match and holds until enable drops
module alarm_unit import clock_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_inc,
	input  pos_e               i_pos,
	input  logic               i_alarm_en,
	input  logic [FIELD_W-1:0] i_sec,
	input  logic [FIELD_W-1:0] i_min,
	input  logic [FIELD_W-1:0] i_hour,
	output logic [FIELD_W-1:0] o_alarm_sec,
	output logic [FIELD_W-1:0] o_alarm_min,
	output logic [FIELD_W-1:0] o_alarm_hour,
	output logic               o_alarm
);

	logic [FIELD_W-1:0] al_sec_q;
	logic [FIELD_W-1:0] al_min_q;
	logic [FIELD_W-1:0] al_hour_q;
	logic               match;
	logic               alarm_q;

	// ------------------------------------------------------------
	// Alarm time setting
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			al_sec_q  <= '0;
			al_min_q  <= '0;
			al_hour_q <= '0;
		end else if (i_inc) begin
			case (i_pos)
				POS_SEC:  al_sec_q  <= inc_wrap(al_sec_q, SEC_MAX);
				POS_MIN:  al_min_q  <= inc_wrap(al_min_q, MIN_MAX);
				POS_HOUR: al_hour_q <= inc_wrap(al_hour_q, HOUR_MAX);
				default: begin
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// Match and latch
	// ------------------------------------------------------------
	assign match = (i_sec == al_sec_q) && (i_min == al_min_q) && (i_hour == al_hour_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= 1'b0;
		end else begin
			alarm_q <= i_alarm_en & (match | alarm_q);
		end
	end

	assign o_alarm_sec  = al_sec_q;
	assign o_alarm_min  = al_min_q;
	assign o_alarm_hour = al_hour_q;
	assign o_alarm      = alarm_q;

endmodule

// ==== rtl/seg_display.sv ====
// Six-digit multiplexed seven-segment driver
// Digit 0 is seconds ones, digit 5 is hours tens
// Enables are active low with one digit on at a time
// Selected field blinks off in setup mode
module seg_display import clock_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_scan_tick,
	input  logic               i_blink,
	input  mode_e              i_mode,
	input  pos_e               i_pos,
	input  logic [FIELD_W-1:0] i_sec,
	input  logic [FIELD_W-1:0] i_min,
	input  logic [FIELD_W-1:0] i_hour,
	input  logic [FIELD_W-1:0] i_alarm_sec,
	input  logic [FIELD_W-1:0] i_alarm_min,
	input  logic [FIELD_W-1:0] i_alarm_hour,
	output logic [SEG_W-1:0]   o_seg,
	output logic               o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	localparam int SCAN_W = $clog2(NUM_DIGITS);

	logic [SCAN_W-1:0]  digit_q;
	logic [1:0]         field_idx;
	logic [FIELD_W-1:0] field;
	logic [DIGIT_W-1:0] digit_val;
	logic               blank;

	// ------------------------------------------------------------
	// Scan counter
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_q <= '0;
		end else if (i_scan_tick) begin
			if (digit_q == SCAN_W'(NUM_DIGITS - 1)) begin
				digit_q <= '0;
			end else begin
				digit_q <= digit_q + 1'b1;
			end
		end
	end

	// Two digits per field in pos_e order
	assign field_idx = 2'(digit_q >> 1);

	// ------------------------------------------------------------
	// Field select and digit split
	// ------------------------------------------------------------
	always_comb begin
		case (field_idx)
			2'd0:    field = (i_mode == MODE_ALARM) ? i_alarm_sec : i_sec;
			2'd1:    field = (i_mode == MODE_ALARM) ? i_alarm_min : i_min;
			default: field = (i_mode == MODE_ALARM) ? i_alarm_hour : i_hour;
		endcase

		if (digit_q[0]) begin
			digit_val = DIGIT_W'(field / 10);
		end else begin
			digit_val = DIGIT_W'(field % 10);
		end
	end

	assign blank = (i_mode == MODE_SETUP) && i_blink && (field_idx == i_pos);

	// ------------------------------------------------------------
	// Segment decode and enables
	// ------------------------------------------------------------
	always_comb begin
		if (blank) begin
			o_seg = SEG_BLANK;
		end else begin
			o_seg = SEG_DIGIT_TABLE[digit_val];
		end
	end

	assign o_seg_enb = blank ? '1 : ~(NUM_DIGITS'(1) << digit_q);

	// Separators after the hours and minutes
	assign o_seg_dp = !blank && (digit_q == SCAN_W'(2) || digit_q == SCAN_W'(4));

endmodule

// ==== rtl/digital_clock.sv ====
// Top level of the six-digit seven-segment clock
// Buttons are raw asynchronous inputs, active high
// Dividers default to a 50 MHz clock and accept any value of 2 or more
module digital_clock import clock_pkg::*; #(
	parameter int SEC_DIV    = DEF_SEC_DIV,
	parameter int SCAN_DIV   = DEF_SCAN_DIV,
	parameter int BLINK_DIV  = DEF_BLINK_DIV,
	parameter int SAMPLE_DIV = DEF_SAMPLE_DIV
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_btn_mode,
	input  logic                  i_btn_pos,
	input  logic                  i_btn_inc,
	input  logic                  i_btn_alarm_en,
	output logic [SEG_W-1:0]      o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic               sec_tick;
	logic               scan_tick;
	logic               blink;
	logic               sample_tick;
	logic [3:0]         press;
	mode_e              mode;
	pos_e               pos;
	logic               alarm_en;
	logic               inc_time;
	logic               inc_alarm;
	logic [FIELD_W-1:0] sec;
	logic [FIELD_W-1:0] min;
	logic [FIELD_W-1:0] hour;
	logic [FIELD_W-1:0] alarm_sec;
	logic [FIELD_W-1:0] alarm_min;
	logic [FIELD_W-1:0] alarm_hour;

	tick_gen #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.BLINK_DIV  (BLINK_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) u_tick_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_sec_tick    (sec_tick),
		.o_scan_tick   (scan_tick),
		.o_blink       (blink),
		.o_sample_tick (sample_tick)
	);

	// Press order matches mode_ctrl
	button_sync u_button_sync (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample_tick (sample_tick),
		.i_btn         ({i_btn_alarm_en, i_btn_inc, i_btn_pos, i_btn_mode}),
		.o_press       (press)
	);

	mode_ctrl u_mode_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_press     (press),
		.o_mode      (mode),
		.o_pos       (pos),
		.o_alarm_en  (alarm_en),
		.o_inc_time  (inc_time),
		.o_inc_alarm (inc_alarm)
	);

	hms_counter u_hms_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.i_mode     (mode),
		.i_pos      (pos),
		.i_inc      (inc_time),
		.o_sec      (sec),
		.o_min      (min),
		.o_hour     (hour)
	);

	alarm_unit u_alarm_unit (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_inc        (inc_alarm),
		.i_pos        (pos),
		.i_alarm_en   (alarm_en),
		.i_sec        (sec),
		.i_min        (min),
		.i_hour       (hour),
		.o_alarm_sec  (alarm_sec),
		.o_alarm_min  (alarm_min),
		.o_alarm_hour (alarm_hour),
		.o_alarm      (o_alarm)
	);

	seg_display u_seg_display (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_scan_tick  (scan_tick),
		.i_blink      (blink),
		.i_mode       (mode),
		.i_pos        (pos),
		.i_sec        (sec),
		.i_min        (min),
		.i_hour       (hour),
		.i_alarm_sec  (alarm_sec),
		.i_alarm_min  (alarm_min),
		.i_alarm_hour (alarm_hour),
		.o_seg        (o_seg),
		.o_seg_dp     (o_seg_dp),
		.o_seg_enb    (o_seg_enb)
	);

endmodule

// ==== sim/digital_clock_assert.sv ====
// Concurrent checks on the clock's output ports
// Alarm enable history is rebuilt from the raw button by its own sampler
// SAMPLE_DIV must match the divider of the bound instance
module digital_clock_assert #(
	parameter int SAMPLE_DIV = 4
) (
	input logic       clk,
	input logic       rst_n,
	input logic       i_btn_alarm_en,
	input logic       o_seg_dp,
	input logic [5:0] o_seg_enb,
	input logic       o_alarm
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;
	int unsigned samp_cnt;
	logic        samp_tick;
	logic [1:0]  btn_sync;
	logic        btn_prev;
	logic        en_model;

	// ------------------------------------------------------------
	// Enable model: sync, sample, toggle on a rising sample
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_cnt  <= 0;
			samp_tick <= 1'b0;
			btn_sync  <= '0;
			btn_prev  <= 1'b0;
			en_model  <= 1'b0;
		end else begin
			samp_cnt  <= (samp_cnt == SAMPLE_DIV - 1) ? 0 : samp_cnt + 1;
			samp_tick <= (samp_cnt == SAMPLE_DIV - 1);
			btn_sync  <= {btn_sync[0], i_btn_alarm_en};
			if (samp_tick) begin
				btn_prev <= btn_sync[1];
				if (btn_sync[1] && !btn_prev) begin
					en_model <= ~en_model;
				end
			end
		end
	end

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~o_seg_enb) <= 1)
	else begin
		fail_count++;
		$error("more than one digit enabled: %b", o_seg_enb);
	end

	// Separators sit on digits 2 and 4 only
	a_dp_slot: assert property (@(posedge clk) disable iff (!rst_n)
		o_seg_dp |-> (o_seg_enb == 6'b111011 || o_seg_enb == 6'b101111))
	else begin
		fail_count++;
		$error("decimal point high with enables %b", o_seg_enb);
	end

	a_alarm_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(en_model) |-> !o_alarm)
	else begin
		fail_count++;
		$error("alarm high while enable was off");
	end

endmodule

bind digital_clock digital_clock_assert #(
	.SAMPLE_DIV (SAMPLE_DIV)
) assert_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.i_btn_alarm_en (i_btn_alarm_en),
	.o_seg_dp       (o_seg_dp),
	.o_seg_enb      (o_seg_enb),
	.o_alarm        (o_alarm)
);

// ==== sim/tb_digital_clock.sv ====
// Testbench for the six-digit clock with small dividers
// Buttons change on the falling edge and outputs are sampled there
// Bound assertion failures end the run like a procedural error
module tb_digital_clock;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEC_DIV    = 20;
	localparam int SCAN_DIV   = 4;
	localparam int BLINK_DIV  = 64;
	localparam int SAMPLE_DIV = 4;
	localparam int HOLD_CYC   = 3 * SAMPLE_DIV;
	localparam int READ_LIMIT = 4 * BLINK_DIV + 24 * SCAN_DIV;

	// Segments a..g for digits 0 to 9
	localparam logic [6:0] DIGIT_SEG [10] = '{
		7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001, 7'b0110011,
		7'b1011011, 7'b1011111, 7'b1110000, 7'b1111111, 7'b1110011
	};

	logic       clk;
	logic       rst_n;
	logic [3:0] btn;
	logic [6:0] seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       alarm;
	int         seed = 95318;
	int         cyc;
	bit         in_setup;
	int         sel_field;

	// Button bits: 0 mode, 1 position, 2 increment, 3 alarm enable
	digital_clock #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.BLINK_DIV  (BLINK_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_btn_mode     (btn[0]),
		.i_btn_pos      (btn[1]),
		.i_btn_inc      (btn[2]),
		.i_btn_alarm_en (btn[3]),
		.o_seg          (seg),
		.o_seg_dp       (seg_dp),
		.o_seg_enb      (seg_enb),
		.o_alarm        (alarm)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	// ------------------------------------------------------------
	// Reporting
	// ------------------------------------------------------------
	task automatic stop_with_fail(input string why);
		$display("Error at %0t: %s", $time, why);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
			stop_with_fail("value mismatch");
		end
	endtask

	always @(negedge clk) begin
		if (dut_i.assert_i.fail_count != 0) begin
			stop_with_fail("a bound assertion failed");
		end
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	function automatic int enabled_digit(input logic [5:0] enb);
		int idx;
		idx = -1;
		for (int i = 0; i < 6; i++) begin
			if (!enb[i]) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	function automatic int decode_seg(input logic [6:0] pattern);
		int val;
		val = -1;
		for (int i = 0; i < 10; i++) begin
			if (pattern == DIGIT_SEG[i]) begin
				val = i;
			end
		end
		return val;
	endfunction

	task automatic press(input int which);
		@(negedge clk);
		btn[which] = 1'b1;
		repeat (HOLD_CYC) @(negedge clk);
		btn[which] = 1'b0;
		repeat (HOLD_CYC) @(negedge clk);
	endtask

	task automatic press_times(input int which, input int n);
		repeat (n) press(which);
	endtask

	// Collects one frame, skipping blanked slots
	task automatic read_display(output int hh, output int mm, output int ss);
		int       digit [6];
		bit [5:0] seen;
		int       k;
		int       val;
		int       waited;
		seen = '0;
		waited = 0;
		while (seen != 6'h3f) begin
			@(negedge clk);
			waited++;
			if (waited > READ_LIMIT) begin
				stop_with_fail("display reader never saw a full frame");
			end
			k = enabled_digit(seg_enb);
			if (k >= 0) begin
				if (in_setup && dut_i.blink && k / 2 == sel_field) begin
					stop_with_fail("selected field enabled while blink is high");
				end
				val = decode_seg(seg);
				if (val < 0) begin
					stop_with_fail($sformatf("o_seg pattern %b is no digit", seg));
				end
				digit[k] = val;
				seen[k] = 1'b1;
			end
		end
		ss = digit[1] * 10 + digit[0];
		mm = digit[3] * 10 + digit[2];
		hh = digit[5] * 10 + digit[4];
	endtask

	// Scan order and patterns in the first frame, all digits zero
	task automatic check_first_frame();
		int k;
		int d;
		int waited;
		for (k = 0; k < 6; k++) begin
			waited = 0;
			d = enabled_digit(seg_enb);
			while (d != k) begin
				if (d != k - 1 || waited > 2 * SCAN_DIV) begin
					stop_with_fail($sformatf("scan did not step to digit %0d", k));
				end
				@(negedge clk);
				waited++;
				d = enabled_digit(seg_enb);
			end
			check_eq("o_seg", seg, DIGIT_SEG[0]);
			check_eq("o_seg_dp", seg_dp, (k == 2 || k == 4));
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		int h0;
		int m0;
		int s0;
		int h;
		int m;
		int s;
		int t_lo;
		int t_hi;
		int lead;
		int al_sec;
		int c_run;
		int waited;
		btn = '0;
		rst_n = 1'b0;
		in_setup = 1'b0;
		sel_field = 0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_eq("o_alarm", alarm, 0);
		check_eq("o_seg_enb", seg_enb, 6'b111110);
		check_first_frame();

		// Run past a minute boundary, then freeze in setup
		repeat ((61 + $unsigned($random(seed)) % 30) * SEC_DIV) @(negedge clk);
		t_lo = cyc / SEC_DIV - 1;
		press(0);
		t_hi = cyc / SEC_DIV + 1;
		in_setup = 1'b1;
		read_display(h0, m0, s0);
		if (s0 > 59 || m0 > 59 || h0 > 23) begin
			stop_with_fail("frozen time has a field out of range");
		end
		if (h0 * 3600 + m0 * 60 + s0 < t_lo || h0 * 3600 + m0 * 60 + s0 > t_hi) begin
			stop_with_fail($sformatf("frozen time outside %0d..%0d s", t_lo, t_hi));
		end
		repeat ((5 + $unsigned($random(seed)) % 5) * SEC_DIV) @(negedge clk);
		read_display(h, m, s);
		check_eq("hours", h, h0);
		check_eq("minutes", m, m0);
		check_eq("seconds", s, s0);

		// Seconds wrap with no carry
		press_times(2, 61);
		read_display(h, m, s);
		check_eq("seconds", s, (s0 + 61) % 60);
		check_eq("minutes", m, m0);
		s0 = (s0 + 61) % 60;

		// Hours up to 23, then wrap to 0
		press_times(1, 2);
		sel_field = 2;
		press_times(2, 23 - h0);
		read_display(h, m, s);
		check_eq("hours", h, 23);
		press(2);
		read_display(h, m, s);
		check_eq("hours", h, 0);
		check_eq("minutes", m, m0);
		press(1);
		sel_field = 0;

		// Alarm two minutes ahead plus a few seconds
		al_sec = 3 + $unsigned($random(seed)) % 4;
		lead = (m0 + 2) * 60 + al_sec - (m0 * 60 + s0);
		c_run = cyc;
		press(0);
		in_setup = 1'b0;
		press_times(2, al_sec);
		press(1);
		press_times(2, m0 + 2);
		read_display(h, m, s);
		check_eq("alarm hours", h, 0);
		check_eq("alarm minutes", m, m0 + 2);
		check_eq("alarm seconds", s, al_sec);
		press(3);
		press(0);

		waited = 0;
		while (!alarm) begin
			@(negedge clk);
			if (cyc - c_run > (lead + 2) * SEC_DIV) begin
				stop_with_fail("alarm did not rise in time");
			end
		end
		if (cyc - c_run < (lead - 1) * SEC_DIV) begin
			stop_with_fail("alarm rose before the alarm time");
		end
		repeat (2 * SEC_DIV) begin
			@(negedge clk);
			check_eq("o_alarm", alarm, 1);
		end
		press(3);
		while (alarm) begin
			@(negedge clk);
			waited++;
			if (waited > HOLD_CYC) begin
				stop_with_fail("alarm did not fall after disable");
			end
		end
		repeat (SEC_DIV) @(negedge clk);

		if (dut_i.assert_i.fail_count != 0) begin
			stop_with_fail("a bound assertion failed");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== digital_clock.f ====
rtl/clock_pkg.sv
rtl/tick_gen.sv
rtl/button_sync.sv
rtl/mode_ctrl.sv
rtl/hms_counter.sv
rtl/alarm_unit.sv
rtl/seg_display.sv
rtl/digital_clock.sv
sim/digital_clock_assert.sv
sim/tb_digital_clock.sv

// ==== Bender.yml ====
package:
  name: digital_clock

sources:
  - rtl/clock_pkg.sv
  - rtl/tick_gen.sv
  - rtl/button_sync.sv
  - rtl/mode_ctrl.sv
  - rtl/hms_counter.sv
  - rtl/alarm_unit.sv
  - rtl/seg_display.sv
  - rtl/digital_clock.sv
  - target: simulation
    files:
      - sim/digital_clock_assert.sv
      - sim/tb_digital_clock.sv
